// ==== pwm_pkg.sv ====
package pwm_pkg;

   // ------------------------------
   // Shared vector types
   // ------------------------------

   // Serial data byte, also used for duty, divisor and timebase count
   typedef logic [7:0] byte_t;

   // Channel address field of a duty command
   typedef logic [6:0] chan_addr_t;

   // ------------------------------
   // Command decoder states
   // ------------------------------

   typedef enum logic [1:0] {
      cmd_idle,
      cmd_period,
      cmd_duty
   } cmd_state_t;

endpackage

// ==== uart_rx.sv ====
`timescale 1ns/1ps
module uart_rx #(
   parameter int CLKS_PER_BIT = 8
) (
   input  logic           clk,
   input  logic           nRst,
   input  logic           rx,
   output logic           rx_valid,
   output pwm_pkg::byte_t rx_data
);
   import pwm_pkg::*;

   localparam int CNT_W = $clog2(CLKS_PER_BIT);
   localparam logic [CNT_W-1:0] HALF_BIT = CNT_W'(CLKS_PER_BIT / 2 - 1);
   localparam logic [CNT_W-1:0] FULL_BIT = CNT_W'(CLKS_PER_BIT - 1);

   typedef enum logic [2:0] {
      s_idle,
      s_start,
      s_data,
      s_stop,
      s_wait
   } rx_state_t;

   rx_state_t        state;
   logic             rx_meta;
   logic             rx_sync;
   logic             rx_prev;
   logic             start_edge;
   logic [CNT_W-1:0] cnt;
   logic [2:0]       bit_idx;
   byte_t            shreg;

   // ------------------------------
   // Input synchronizer
   // ------------------------------
   always_ff @(posedge clk or negedge nRst) begin
      if (!nRst) begin
         rx_meta <= 1'b1;
         rx_sync <= 1'b1;
         rx_prev <= 1'b1;
      end else begin
         rx_meta <= rx;
         rx_sync <= rx_meta;
         rx_prev <= rx_sync;
      end
   end

   assign start_edge = rx_prev & ~rx_sync;

   // ------------------------------
   // Frame FSM
   // ------------------------------
   always_ff @(posedge clk or negedge nRst) begin
      if (!nRst) begin
         state    <= s_idle;
         cnt      <= '0;
         bit_idx  <= '0;
         rx_valid <= 1'b0;
      end else begin
         rx_valid <= 1'b0;
         case (state)
            s_idle: begin
               cnt <= '0;
               if (start_edge)
                  state <= s_start;
            end
            s_start: begin
               if (cnt == HALF_BIT) begin
                  cnt     <= '0;
                  bit_idx <= '0;
                  // Line back high at mid-bit means a glitch
                  state   <= rx_sync ? s_idle : s_data;
               end else begin
                  cnt <= cnt + 1'b1;
               end
            end
            s_data: begin
               if (cnt == FULL_BIT) begin
                  cnt     <= '0;
                  bit_idx <= bit_idx + 1'b1;
                  if (bit_idx == 3'd7)
                     state <= s_stop;
               end else begin
                  cnt <= cnt + 1'b1;
               end
            end
            s_stop: begin
               if (cnt == FULL_BIT) begin
                  cnt <= '0;
                  if (rx_sync) begin
                     rx_valid <= 1'b1;
                     state    <= s_idle;
                  end else begin
                     state    <= s_wait;
                  end
               end else begin
                  cnt <= cnt + 1'b1;
               end
            end
            s_wait: begin
               // Framing error, hold off until the line idles high
               if (rx_sync)
                  state <= s_idle;
            end
            default: state <= s_idle;
         endcase
      end
   end

   // LSB arrives first
   always_ff @(posedge clk) begin
      if (state == s_data && cnt == FULL_BIT)
         shreg <= {rx_sync, shreg[7:1]};
   end

   assign rx_data = shreg;

endmodule

// ==== pwm_cmd_decoder.sv ====
`timescale 1ns/1ps
module pwm_cmd_decoder #(
   parameter int NUM_CH = 5
) (
   input  logic               clk,
   input  logic               nRst,
   input  logic               rx_valid,
   input  pwm_pkg::byte_t     rx_data,
   output logic               div_we,
   output pwm_pkg::byte_t     div_val,
   output logic               duty_we,
   output pwm_pkg::chan_addr_t duty_ch,
   output pwm_pkg::byte_t     duty_val
);
   import pwm_pkg::*;

   cmd_state_t state;
   chan_addr_t addr;
   logic       addr_ok;

   assign addr_ok = int'(addr) < NUM_CH;

   // ------------------------------
   // Two-byte command FSM
   // ------------------------------
   always_ff @(posedge clk or negedge nRst) begin
      if (!nRst) begin
         state   <= cmd_idle;
         div_we  <= 1'b0;
         duty_we <= 1'b0;
      end else begin
         div_we  <= 1'b0;
         duty_we <= 1'b0;
         if (rx_valid) begin
            case (state)
               cmd_idle: begin
                  state <= rx_data[7] ? cmd_period : cmd_duty;
               end
               cmd_period: begin
                  div_we <= 1'b1;
                  state  <= cmd_idle;
               end
               cmd_duty: begin
                  // Out of range address is swallowed
                  duty_we <= addr_ok;
                  state   <= cmd_idle;
               end
               default: state <= cmd_idle;
            endcase
         end
      end
   end

   // Address and payload registers
   always_ff @(posedge clk) begin
      if (rx_valid) begin
         case (state)
            cmd_idle: begin
               addr <= rx_data[6:0];
            end
            cmd_period: begin
               div_val <= rx_data;
            end
            cmd_duty: begin
               duty_ch  <= addr;
               duty_val <= rx_data;
            end
            default: ;
         endcase
      end
   end

endmodule

// ==== pwm_timebase.sv ====
`timescale 1ns/1ps
module pwm_timebase (
   input  logic           clk,
   input  logic           nRst,
   input  logic           div_we,
   input  pwm_pkg::byte_t div_val,
   output pwm_pkg::byte_t count
);
   import pwm_pkg::*;

   byte_t div_q;
   byte_t presc;
   logic  tick;

   // One tick every div_q+1 clocks
   assign tick = (presc == div_q);

   // ------------------------------
   // Divisor and prescaler
   // ------------------------------
   always_ff @(posedge clk or negedge nRst) begin
      if (!nRst) begin
         div_q <= '0;
         presc <= '0;
      end else if (div_we) begin
         // New interval starts right away
         div_q <= div_val;
         presc <= '0;
      end else if (tick) begin
         presc <= '0;
      end else begin
         presc <= presc + 1'b1;
      end
   end

   // ------------------------------
   // PWM counter
   // ------------------------------
   always_ff @(posedge clk or negedge nRst) begin
      if (!nRst) begin
         count <= '0;
      end else if (tick && !div_we) begin
         count <= count + 1'b1;
      end
   end

endmodule

// ==== pwm_channel_bank.sv ====
`timescale 1ns/1ps
module pwm_channel_bank #(
   parameter int NUM_CH = 5
) (
   input  logic                clk,
   input  logic                nRst,
   input  logic                duty_we,
   input  pwm_pkg::chan_addr_t duty_ch,
   input  pwm_pkg::byte_t      duty_val,
   input  pwm_pkg::byte_t      count,
   output logic [NUM_CH-1:0]   pwm
);
   import pwm_pkg::*;

   byte_t duty [NUM_CH];

   // ------------------------------
   // Per-channel duty and compare
   // ------------------------------
   for (genvar g = 0; g < NUM_CH; g++) begin : g_ch

      logic sel;

      assign sel = duty_we && (duty_ch == chan_addr_t'(g));

      always_ff @(posedge clk or negedge nRst) begin
         if (!nRst) begin
            duty[g] <= '0;
         end else if (sel) begin
            duty[g] <= duty_val;
         end
      end

      // Registered compare keeps the output glitch free
      always_ff @(posedge clk or negedge nRst) begin
         if (!nRst) begin
            pwm[g] <= 1'b0;
         end else begin
            pwm[g] <= (count < duty[g]);
         end
      end

   end

endmodule

// ==== uart2pwm.sv ====
`timescale 1ns/1ps
module uart2pwm #(
   parameter int NUM_CH       = 5,
   parameter int CLKS_PER_BIT = 8
) (
   input  logic              clk,
   input  logic              nRst,
   input  logic              rx,
   output logic [NUM_CH-1:0] pwm
);
   import pwm_pkg::*;

   logic       rx_valid;
   byte_t      rx_data;
   logic       div_we;
   byte_t      div_val;
   logic       duty_we;
   chan_addr_t duty_ch;
   byte_t      duty_val;
   byte_t      count;

   // ------------------------------
   // Command path
   // ------------------------------
   uart_rx #(
      .CLKS_PER_BIT (CLKS_PER_BIT)
   ) uart_rx_i (
      .clk      (clk),
      .nRst     (nRst),
      .rx       (rx),
      .rx_valid (rx_valid),
      .rx_data  (rx_data)
   );

   pwm_cmd_decoder #(
      .NUM_CH (NUM_CH)
   ) pwm_cmd_decoder_i (
      .clk      (clk),
      .nRst     (nRst),
      .rx_valid (rx_valid),
      .rx_data  (rx_data),
      .div_we   (div_we),
      .div_val  (div_val),
      .duty_we  (duty_we),
      .duty_ch  (duty_ch),
      .duty_val (duty_val)
   );

   // ------------------------------
   // Timebase and outputs
   // ------------------------------
   pwm_timebase pwm_timebase_i (
      .clk     (clk),
      .nRst    (nRst),
      .div_we  (div_we),
      .div_val (div_val),
      .count   (count)
   );

   pwm_channel_bank #(
      .NUM_CH (NUM_CH)
   ) pwm_channel_bank_i (
      .clk      (clk),
      .nRst     (nRst),
      .duty_we  (duty_we),
      .duty_ch  (duty_ch),
      .duty_val (duty_val),
      .count    (count),
      .pwm      (pwm)
   );

endmodule

// ==== uart2pwm_chk.sv ====
`timescale 1ns/1ps
module uart2pwm_chk #(
   parameter int W = 1
) (
   input logic         clk,
   input logic         nRst,
   input logic         div_we,
   input logic         duty_we,
   input logic [W-1:0] pwm
);

   int fails = 0;

   // ------------------------------
   // Decoder strobes
   // ------------------------------
   strobes_exclusive: assert property (@(posedge clk) disable iff (!nRst)
      !(div_we && duty_we))
      else begin
         $error("divisor and duty write strobes high in the same cycle");
         fails++;
      end

   div_we_single: assert property (@(posedge clk) disable iff (!nRst)
      div_we |=> !div_we)
      else begin
         $error("divisor write strobe longer than one cycle");
         fails++;
      end

   duty_we_single: assert property (@(posedge clk) disable iff (!nRst)
      duty_we |=> !duty_we)
      else begin
         $error("duty write strobe longer than one cycle");
         fails++;
      end

   // Outputs
   pwm_known: assert property (@(posedge clk) disable iff (!nRst)
      !$isunknown(pwm))
      else begin
         $error("pwm output unknown after reset");
         fails++;
      end

endmodule

bind pwm_cmd_decoder uart2pwm_chk #(.W(1)) chk_dec_i (
   .clk (clk), .nRst (nRst), .div_we (div_we), .duty_we (duty_we), .pwm (1'b0)
);

bind pwm_channel_bank uart2pwm_chk #(.W(NUM_CH)) chk_bank_i (
   .clk (clk), .nRst (nRst), .div_we (1'b0), .duty_we (duty_we), .pwm (pwm)
);

// ==== tb_uart2pwm.sv ====
`timescale 1ns/1ps
module tb_uart2pwm;
   import pwm_pkg::*;

   localparam int NUM_CH = 5;
   localparam int CPB    = 8;

   logic              clk;
   logic              nRst;
   logic              rx;
   logic [NUM_CH-1:0] pwm;

   int    errors;
   int    tests;
   int    failed_tests;
   int    chk_fails;
   int    div_model;
   int    duty_model [NUM_CH];

   uart2pwm #(
      .NUM_CH       (NUM_CH),
      .CLKS_PER_BIT (CPB)
   ) uart2pwm_i (
      .clk  (clk),
      .nRst (nRst),
      .rx   (rx),
      .pwm  (pwm)
   );

   always #4 clk = ~clk;

   // ------------------------------
   // Serial driver
   // ------------------------------
   task automatic drive_bit(input logic v);
      int i;
      rx = v;
      for (i = 0; i < CPB; i++)
         @(negedge clk);
   endtask

   task automatic send_byte(input byte_t b, input logic bad_stop);
      int i;
      @(negedge clk);
      drive_bit(1'b0);
      for (i = 0; i < 8; i++)
         drive_bit(b[i]);
      drive_bit(bad_stop ? 1'b0 : 1'b1);
      // Idle gap before the next frame
      drive_bit(1'b1);
      drive_bit(1'b1);
   endtask

   task automatic send_cmd(input byte_t first, input byte_t second);
      send_byte(first, 1'b0);
      send_byte(second, 1'b0);
   endtask

   task automatic write_duty(input int ch, input byte_t val);
      send_cmd(byte_t'(ch), val);
      if (ch < NUM_CH)
         duty_model[ch] = val;
   endtask

   task automatic write_period(input byte_t d);
      send_cmd(8'h80, d);
      div_model = d;
   endtask

   // ------------------------------
   // Measurement and checks
   // ------------------------------
   task automatic measure_high(input int ch, input int div, output int n);
      int period;
      int i;
      period = 256 * (div + 1);
      n = 0;
      // Let one full period pass so the waveform is steady
      for (i = 0; i < period; i++)
         @(negedge clk);
      for (i = 0; i < period; i++) begin
         @(negedge clk);
         if (pwm[ch])
            n++;
      end
   endtask

   task automatic check_channels();
      int ch;
      int got;
      int exp;
      for (ch = 0; ch < NUM_CH; ch++) begin
         measure_high(ch, div_model, got);
         exp = duty_model[ch] * (div_model + 1);
         assert (got == exp)
         else begin
            $display("Error at %0t: channel %0d high for %0d clocks, expected %0d",
                     $time, ch, got, exp);
            errors++;
         end
      end
   endtask

   task automatic finish_test(input string name, input int errs_before);
      tests++;
      if (errors == errs_before) begin
         $display("test %s: ok", name);
      end else begin
         failed_tests++;
         $display("test %s: failed with %0d errors", name, errors - errs_before);
      end
   endtask

   // ------------------------------
   // Tests
   // ------------------------------
   task automatic reset_keeps_low();
      int e0;
      e0 = errors;
      check_channels();
      finish_test("reset_low", e0);
   endtask

   task automatic random_duties();
      int e0;
      int ch;
      e0 = errors;
      for (ch = 0; ch < NUM_CH; ch++)
         write_duty(ch, byte_t'($urandom));
      check_channels();
      // Rewrite one channel, the rest must hold
      write_duty(2, byte_t'($urandom));
      check_channels();
      finish_test("random_duty", e0);
   endtask

   task automatic period_scaling();
      int e0;
      e0 = errors;
      write_period(8'd2);
      check_channels();
      finish_test("period_scale", e0);
   endtask

   task automatic bad_address_ignored();
      int e0;
      e0 = errors;
      write_duty(NUM_CH, 8'hff);
      write_duty(127, 8'h00);
      check_channels();
      write_duty(0, byte_t'($urandom));
      check_channels();
      finish_test("bad_address", e0);
   endtask

   task automatic bad_stop_dropped();
      int e0;
      e0 = errors;
      // Would address channel 2 if framing slipped
      send_byte(8'h02, 1'b1);
      write_duty(1, 8'h5a);
      check_channels();
      finish_test("bad_stop", e0);
   endtask

   task automatic duty_extremes();
      int e0;
      e0 = errors;
      write_duty(3, 8'd0);
      write_duty(4, 8'd255);
      check_channels();
      finish_test("duty_extremes", e0);
   endtask

   initial begin
      int ch;
      void'($urandom(32'hf922_4b95));
      errors       = 0;
      tests        = 0;
      failed_tests = 0;
      chk_fails    = 0;
      div_model    = 0;
      for (ch = 0; ch < NUM_CH; ch++)
         duty_model[ch] = 0;
      clk  = 1'b0;
      rx   = 1'b1;
      nRst = 1'b0;
      repeat (2) @(negedge clk);
      nRst = 1'b1;
      repeat (4) @(negedge clk);

      reset_keeps_low();
      random_duties();
      period_scaling();
      bad_address_ignored();
      bad_stop_dropped();
      duty_extremes();

      chk_fails = uart2pwm_i.pwm_cmd_decoder_i.chk_dec_i.fails
                + uart2pwm_i.pwm_channel_bank_i.chk_bank_i.fails;
      $display("%0d tests run, %0d failed, %0d errors, %0d assertion failures",
               tests, failed_tests, errors, chk_fails);
      if (errors == 0 && chk_fails == 0) begin
         $display("PASS: all tests");
      end else begin
         $display("FAIL: see errors above");
      end
      $finish;
   end

endmodule

// ==== verilog.f ====
pwm_pkg.sv
uart_rx.sv
pwm_cmd_decoder.sv
pwm_timebase.sv
pwm_channel_bank.sv
uart2pwm.sv
uart2pwm_chk.sv
tb_uart2pwm.sv

// ==== Bender.yml ====
package:
  name: uart2pwm

sources:
  - pwm_pkg.sv
  - uart_rx.sv
  - pwm_cmd_decoder.sv
  - pwm_timebase.sv
  - pwm_channel_bank.sv
  - uart2pwm.sv
  - target: simulation
    files:
      - uart2pwm_chk.sv
      - tb_uart2pwm.sv
